// File: verilog/router_cfg.svh
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// Mesh coordinate and cache bank address widths
`define ROUTER_COORD_WIDTH 2
`define ROUTER_BANK_ADDR_WIDTH 4

`define ROUTER_DATA_WIDTH 16

// Storage sizes
`define ROUTER_FIFO_DEPTH 4
`define ROUTER_BANK_DEPTH 16

`endif

// File: verilog/routerPkg.sv
`default_nettype none
`include "router_cfg.svh"

package routerPkg;

	typedef struct packed {
		logic [`ROUTER_COORD_WIDTH-1:0] x;
		logic [`ROUTER_COORD_WIDTH-1:0] y;
	} nodeAddrT;

	typedef struct packed {
		nodeAddrT node;
		logic [`ROUTER_BANK_ADDR_WIDTH-1:0] bank;
	} destAddrT;

	typedef struct packed {
		destAddrT dest;
		nodeAddrT requester;
		logic read;
		logic write;
		logic [`ROUTER_DATA_WIDTH-1:0] data;
	} packetT;

	typedef enum logic [2:0] {
		North,
		South,
		East,
		West,
		Local
	} directionT;

	typedef struct packed {
		packetT packet;
		directionT direction;
	} routedPacketT;

	// Dimension order, X first then Y
	function automatic directionT routeDirection(input nodeAddrT dest, input nodeAddrT here);
		if (dest.x > here.x) begin
			return East;
		end else if (dest.x < here.x) begin
			return West;
		end else if (dest.y > here.y) begin
			return North;
		end else if (dest.y < here.y) begin
			return South;
		end
		return Local;
	endfunction

endpackage

`default_nettype wire

// File: verilog/portHandler.sv
`default_nettype none

module portHandler (
	input logic clk,
	input logic reset,
	input routerPkg::nodeAddrT localAddr,

	// Four-phase input link
	input logic inReq,
	output logic inAck,
	input routerPkg::packetT inPacket,

	// FIFO write side
	output logic push,
	output routerPkg::routedPacketT pushData,
	input logic full
);

	import routerPkg::*;

	logic accept;

	// New request, previous one fully released, room in the FIFO
	assign accept = inReq && !inAck && !full;

	// The FIFO captures the packet on the same edge that raises inAck
	assign push = accept;
	assign pushData.packet = inPacket;
	assign pushData.direction = routeDirection(inPacket.dest.node, localAddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			inAck <= 1'b0;
		end else if (accept) begin
			inAck <= 1'b1;
		end else if (!inReq) begin
			// Return to zero once the sender drops req
			inAck <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/packetFifo.sv
`default_nettype none
`include "router_cfg.svh"

module packetFifo (
	input logic clk,
	input logic reset,

	input logic push,
	input routerPkg::routedPacketT pushData,
	output logic full,

	input logic pop,
	output routerPkg::routedPacketT popData,
	output logic empty
);

	import routerPkg::*;

	localparam int Depth = `ROUTER_FIFO_DEPTH;
	localparam int PtrWidth = $clog2(Depth);
	localparam int CountWidth = $clog2(Depth + 1);
	localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

	routedPacketT entries [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic doPush;
	logic doPop;

	assign full = (count == CountWidth'(Depth));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign popData = entries[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			entries[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cacheBank.sv
`default_nettype none
`include "router_cfg.svh"

module cacheBank (
	input logic clk,
	input logic bankWrite,
	input logic [`ROUTER_BANK_ADDR_WIDTH-1:0] bankAddr,
	input logic [`ROUTER_DATA_WIDTH-1:0] bankWriteData,
	output logic [`ROUTER_DATA_WIDTH-1:0] bankReadData
);

	logic [`ROUTER_DATA_WIDTH-1:0] words [`ROUTER_BANK_DEPTH];

	// Registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		if (bankWrite) begin
			words[bankAddr] <= bankWriteData;
		end
		bankReadData <= words[bankAddr];
	end

endmodule

`default_nettype wire

// File: verilog/bankAccess.sv
`default_nettype none
`include "router_cfg.svh"

module bankAccess (
	input logic clk,
	input logic reset,
	input routerPkg::nodeAddrT localAddr,

	// FIFO read side
	input routerPkg::routedPacketT popData,
	input logic empty,
	output logic pop,

	// Four-phase output link
	output logic outReq,
	input logic outAck,
	output routerPkg::routedPacketT outPacket
);

	import routerPkg::*;

	localparam int AddrWidth = `ROUTER_BANK_ADDR_WIDTH;
	localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(`ROUTER_BANK_DEPTH - 1);

	typedef enum logic [2:0] {
		Clear,
		Idle,
		ReadWait,
		Send,
		Release
	} stateT;

	stateT state;
	logic [AddrWidth-1:0] clearAddr;
	logic isLocal;
	logic localWrite;
	logic localRead;
	logic bankWrite;
	logic [AddrWidth-1:0] bankAddr;
	logic [`ROUTER_DATA_WIDTH-1:0] bankWriteData;
	logic [`ROUTER_DATA_WIDTH-1:0] bankReadData;

	// Write wins when both flags are set
	assign isLocal = (popData.direction == Local);
	assign localWrite = isLocal && popData.packet.write;
	assign localRead = isLocal && popData.packet.read && !popData.packet.write;

	// Only take the head while the link is idle
	assign pop = (state == Idle) && !empty;
	assign outReq = (state == Send);

	always_comb begin
		bankWrite = pop && localWrite;
		bankAddr = popData.packet.dest.bank;
		bankWriteData = popData.packet.data;
		// Zero the bank word by word after reset
		if (state == Clear) begin
			bankWrite = 1'b1;
			bankAddr = clearAddr;
			bankWriteData = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Clear;
			clearAddr <= '0;
		end else begin
			case (state)
				Clear: begin
					clearAddr <= clearAddr + 1'b1;
					if (clearAddr == LastAddr) begin
						state <= Idle;
					end
				end
				Idle: begin
					if (pop && localRead) begin
						state <= ReadWait;
					end else if (pop && !localWrite) begin
						state <= Send;
					end
				end
				ReadWait: state <= Send;
				Send: begin
					if (outAck) begin
						state <= Release;
					end
				end
				Release: begin
					if (!outAck) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Output payload, held steady from Send until Idle
	always_ff @(posedge clk) begin
		if (pop && localRead) begin
			outPacket.packet.dest.node <= popData.packet.requester;
			outPacket.packet.dest.bank <= popData.packet.dest.bank;
			outPacket.packet.requester <= localAddr;
			outPacket.packet.read <= 1'b0;
			outPacket.packet.write <= 1'b0;
			outPacket.direction <= routeDirection(popData.packet.requester, localAddr);
		end else if (pop && !localWrite) begin
			outPacket <= popData;
		end
		if (state == ReadWait) begin
			outPacket.packet.data <= bankReadData;
		end
	end

	cacheBank bank (
		.clk(clk),
		.bankWrite(bankWrite),
		.bankAddr(bankAddr),
		.bankWriteData(bankWriteData),
		.bankReadData(bankReadData)
	);

endmodule

`default_nettype wire

// File: verilog/routerTop.sv
`default_nettype none

module routerTop (
	input logic clk,
	input logic reset,
	input routerPkg::nodeAddrT localAddr,

	input logic inReq,
	output logic inAck,
	input routerPkg::packetT inPacket,

	output logic outReq,
	input logic outAck,
	output routerPkg::routedPacketT outPacket
);

	import routerPkg::*;

	logic push;
	logic full;
	logic pop;
	logic empty;
	routedPacketT pushData;
	routedPacketT popData;

	portHandler inPort (
		.clk(clk),
		.reset(reset),
		.localAddr(localAddr),
		.inReq(inReq),
		.inAck(inAck),
		.inPacket(inPacket),
		.push(push),
		.pushData(pushData),
		.full(full)
	);

	packetFifo fifo (
		.clk(clk),
		.reset(reset),
		.push(push),
		.pushData(pushData),
		.full(full),
		.pop(pop),
		.popData(popData),
		.empty(empty)
	);

	bankAccess access (
		.clk(clk),
		.reset(reset),
		.localAddr(localAddr),
		.popData(popData),
		.empty(empty),
		.pop(pop),
		.outReq(outReq),
		.outAck(outAck),
		.outPacket(outPacket)
	);

endmodule

`default_nettype wire

// File: tb/routerTop_properties.sv
`default_nettype none
`include "router_cfg.svh"

module routerTop_properties (
	input logic clk,
	input logic reset,
	input logic inReq,
	input logic inAck,
	input logic push,
	input logic pop,
	input logic outReq,
	input logic outAck,
	input routerPkg::routedPacketT outPacket
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int OccWidth = $clog2(`ROUTER_FIFO_DEPTH + 1);
	localparam logic [OccWidth-1:0] Depth = OccWidth'(`ROUTER_FIFO_DEPTH);

	logic [OccWidth-1:0] occupancy;

	// Packet FIFO fill level, tracked from its push and pop strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	// Payload frozen until the receiver acks
	property outPacketHeld;
		@(posedge clk) disable iff (reset)
		outReq && !outAck |=> $stable(outPacket);
	endproperty

	property inAckNeedsReq;
		@(posedge clk) disable iff (reset)
		!inReq && !inAck |=> !inAck;
	endproperty

	property noPushWhenFull;
		@(posedge clk) disable iff (reset)
		push |-> occupancy != Depth;
	endproperty

	assert property (outPacketHeld)
		else $error("outPacket changed while outReq waited for outAck");
	assert property (inAckNeedsReq)
		else $error("inAck rose without inReq");
	assert property (noPushWhenFull)
		else $error("push while the packet FIFO was full");

endmodule

bind routerTop routerTop_properties props (
	.clk(clk),
	.reset(reset),
	.inReq(inReq),
	.inAck(inAck),
	.push(push),
	.pop(pop),
	.outReq(outReq),
	.outAck(outAck),
	.outPacket(outPacket)
);

`default_nettype wire

// File: tb/routerChecker.sv
`default_nettype none
`include "router_cfg.svh"

module routerChecker (
	input logic clk,
	input logic reset,
	input logic outReq,
	input routerPkg::routedPacketT outPacket,
	output int errorCount,
	output int packetCount,
	output int pendingCount
);

	timeunit 1ns;
	timeprecision 100ps;

	import routerPkg::*;

	routedPacketT expected [$];

	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%h expected 0x%h", name, got, want);
			errorCount++;
		end
	endtask

	task automatic checkPacket();
		routedPacketT want;
		if (expected.size() == 0) begin
			$display("Unexpected extra packet on the output link at %0t", $time);
			errorCount++;
		end else begin
			want = expected.pop_front();
			compareField("outPacket.packet.dest", 32'(outPacket.packet.dest),
				32'(want.packet.dest));
			compareField("outPacket.packet.requester", 32'(outPacket.packet.requester),
				32'(want.packet.requester));
			compareField("outPacket.packet.read", 32'(outPacket.packet.read),
				32'(want.packet.read));
			compareField("outPacket.packet.write", 32'(outPacket.packet.write),
				32'(want.packet.write));
			compareField("outPacket.packet.data", 32'(outPacket.packet.data),
				32'(want.packet.data));
			compareField("outPacket.direction", 32'(outPacket.direction),
				32'(want.direction));
			packetCount++;
		end
		pendingCount = expected.size();
	endtask

	initial begin
		int fd;
		int n;
		int f [18];
		string line;
		routedPacketT want;
		logic lastReq;
		errorCount = 0;
		packetCount = 0;
		lastReq = 1'b0;
		fd = $fopen("tb/router_cases.txt", "r");
		if (fd == 0) begin
			$display("Checker cannot open tb/router_cases.txt");
			errorCount++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
				// Lines marked none stop after the stimulus columns
				if (n == 18) begin
					want.packet.dest.node.x = f[9][`ROUTER_COORD_WIDTH-1:0];
					want.packet.dest.node.y = f[10][`ROUTER_COORD_WIDTH-1:0];
					want.packet.dest.bank = f[11][`ROUTER_BANK_ADDR_WIDTH-1:0];
					want.packet.requester.x = f[12][`ROUTER_COORD_WIDTH-1:0];
					want.packet.requester.y = f[13][`ROUTER_COORD_WIDTH-1:0];
					want.packet.read = f[14][0];
					want.packet.write = f[15][0];
					want.packet.data = f[16][`ROUTER_DATA_WIDTH-1:0];
					want.direction = directionT'(f[17][2:0]);
					expected.push_back(want);
				end
			end
			$fclose(fd);
		end
		pendingCount = expected.size();
		forever begin
			@(posedge clk);
			// Compare once per request, on its rising edge
			if (!reset && outReq && !lastReq) begin
				checkPacket();
			end
			lastReq = reset ? 1'b0 : outReq;
		end
	end

endmodule

`default_nettype wire

// File: tb/routerTb.sv
`default_nettype none
`include "router_cfg.svh"

module routerTb;

	timeunit 1ns;
	timeprecision 100ps;

	import routerPkg::*;

	localparam int TimeoutCycles = 400;
	localparam int StallCycles = 8;

	logic clk;
	logic reset;
	nodeAddrT localAddr;
	logic inReq;
	logic inAck;
	packetT inPacket;
	logic outReq;
	logic outAck;
	routedPacketT outPacket;

	packetT stimulus [$];
	int ackDelays [$];
	int tbErrors;
	int checkErrors;
	int packetCount;
	int pendingCount;
	logic stallSeen;

	routerTop i_dut (
		.clk(clk),
		.reset(reset),
		.localAddr(localAddr),
		.inReq(inReq),
		.inAck(inAck),
		.inPacket(inPacket),
		.outReq(outReq),
		.outAck(outAck),
		.outPacket(outPacket)
	);

	routerChecker outputCheck (
		.clk(clk),
		.reset(reset),
		.outReq(outReq),
		.outPacket(outPacket),
		.errorCount(checkErrors),
		.packetCount(packetCount),
		.pendingCount(pendingCount)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic readCases();
		int fd;
		int n;
		int f [18];
		string line;
		packetT pkt;
		fd = $fopen("tb/router_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tb/router_cases.txt");
			tbErrors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
			if (n >= 9) begin
				pkt.dest.node.x = f[0][`ROUTER_COORD_WIDTH-1:0];
				pkt.dest.node.y = f[1][`ROUTER_COORD_WIDTH-1:0];
				pkt.dest.bank = f[2][`ROUTER_BANK_ADDR_WIDTH-1:0];
				pkt.requester.x = f[3][`ROUTER_COORD_WIDTH-1:0];
				pkt.requester.y = f[4][`ROUTER_COORD_WIDTH-1:0];
				pkt.read = f[5][0];
				pkt.write = f[6][0];
				pkt.data = f[7][`ROUTER_DATA_WIDTH-1:0];
				stimulus.push_back(pkt);
				// Ack delay only matters for packets that come out
				if (n == 18) begin
					ackDelays.push_back(f[8]);
				end
			end
		end
		$fclose(fd);
		if (stimulus.size() == 0) begin
			$display("No packets found in tb/router_cases.txt");
			tbErrors++;
		end
	endtask

	task automatic waitForInAck(input logic level, output int waited);
		waited = 0;
		while (inAck !== level && waited < TimeoutCycles) begin
			@(posedge clk);
			waited++;
		end
		if (inAck !== level) begin
			$display("Timeout: inAck did not go to %0b within %0d cycles", level, TimeoutCycles);
			tbErrors++;
		end
	endtask

	task automatic waitForOutReq(input logic level);
		int waited;
		waited = 0;
		while (outReq !== level && waited < TimeoutCycles) begin
			@(posedge clk);
			waited++;
		end
		if (outReq !== level) begin
			$display("Timeout: outReq did not go to %0b within %0d cycles", level, TimeoutCycles);
			tbErrors++;
		end
	endtask

	task automatic sendPacket(input packetT pkt);
		int waited;
		repeat ($urandom_range(0, 3)) @(posedge clk);
		@(posedge clk);
		inPacket <= pkt;
		inReq <= 1'b1;
		waitForInAck(1'b1, waited);
		// A long wait here means the FIFO pushed back
		if (waited >= StallCycles) begin
			stallSeen = 1'b1;
		end
		inReq <= 1'b0;
		waitForInAck(1'b0, waited);
	endtask

	task automatic sendAll();
		foreach (stimulus[i]) begin
			sendPacket(stimulus[i]);
		end
	endtask

	task automatic ackPackets();
		int delay;
		foreach (ackDelays[i]) begin
			waitForOutReq(1'b1);
			delay = ackDelays[i] + int'($urandom_range(0, 3));
			repeat (delay) @(posedge clk);
			outAck <= 1'b1;
			waitForOutReq(1'b0);
			outAck <= 1'b0;
		end
	endtask

	initial begin
		tbErrors = 0;
		stallSeen = 1'b0;
		reset = 1'b1;
		inReq = 1'b0;
		inPacket = '0;
		outAck = 1'b0;
		localAddr.x = 1;
		localAddr.y = 1;
		void'($urandom(32'hfd63_6ad3));
		readCases();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		fork
			sendAll();
			ackPackets();
		join
		// Quiet period so a stray extra packet still gets caught
		repeat (20) @(posedge clk);
		if (!stallSeen) begin
			$display("inAck never stalled while the output link was held back");
			tbErrors++;
		end
		if (pendingCount != 0) begin
			$display("%0d expected packets never appeared on the output link", pendingCount);
			tbErrors++;
		end
		$display("Summary: %0d packets checked, %0d compare errors, %0d other errors",
			packetCount, checkErrors, tbErrors);
		if (checkErrors == 0 && tbErrors == 0 && packetCount > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/router_cases.txt
# in: dx dy bank rx ry rd wr data ackDelay, then out: dx dy bank rx ry rd wr data dir, or none
# all hex; dir 0 North 1 South 2 East 3 West 4 Local; localAddr is 1,1
3 1 2 0 0 0 0 1234 0  3 1 2 0 0 0 0 1234 2
0 2 4 1 1 0 0 2345 0  0 2 4 1 1 0 0 2345 3
1 3 6 2 0 0 0 3456 0  1 3 6 2 0 0 0 3456 0
1 0 8 3 3 0 0 4567 0  1 0 8 3 3 0 0 4567 1
2 0 a 0 1 1 0 5678 0  2 0 a 0 1 1 0 5678 2
1 1 5 2 1 0 1 beef 0  none
1 1 5 3 2 1 0 0000 0  3 2 5 1 1 0 0 beef 2
1 1 5 1 0 1 0 0000 0  1 0 5 1 1 0 0 beef 1
1 1 9 0 1 1 0 0000 0  0 1 9 1 1 0 0 0000 3
1 1 3 2 2 0 0 0a0a 0  1 1 3 2 2 0 0 0a0a 4
3 3 0 0 0 0 0 1111 40 3 3 0 0 0 0 0 1111 2
0 0 1 2 2 0 0 2222 0  0 0 1 2 2 0 0 2222 3
1 1 7 0 0 0 1 3333 0  none
1 2 2 0 3 0 0 4444 0  1 2 2 0 3 0 0 4444 0
1 1 7 1 2 1 0 0000 0  1 2 7 1 1 0 0 3333 0
1 1 1 0 3 0 0 5555 0  1 1 1 0 3 0 0 5555 4
2 1 e 1 1 0 0 6666 0  2 1 e 1 1 0 0 6666 2
1 0 f 3 0 0 0 7777 0  1 0 f 3 0 0 0 7777 1

// File: vlog.f
+incdir+verilog
verilog/routerPkg.sv
verilog/portHandler.sv
verilog/packetFifo.sv
verilog/cacheBank.sv
verilog/bankAccess.sv
verilog/routerTop.sv
tb/routerTop_properties.sv
tb/routerChecker.sv
tb/routerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= routerTb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
